/* sources.f */
hw/md_bus_pkg.sv
hw/mbus_decode.sv
hw/work_ram.sv
hw/zbus_unit.sv
hw/mbus_ctrl.sv
hw/md_bus_top.sv
testbench/tb_clock.sv
testbench/md_bus_properties.sv
testbench/md_bus_tb.sv

/* Bender.yml */
package:
  name: md_bus

sources:
  - files:
      - hw/md_bus_pkg.sv
      - hw/mbus_decode.sv
      - hw/work_ram.sv
      - hw/zbus_unit.sv
      - hw/mbus_ctrl.sv
      - hw/md_bus_top.sv
  - target: test
    files:
      - testbench/tb_clock.sv
      - testbench/md_bus_properties.sv
      - testbench/md_bus_tb.sv

/* testbench/md_bus_tb.sv */
// Table-driven testbench for the console system bus
// ROM is 16K words; the ROM model answers after a random delay with the
// inverted word address. Addresses in the table are byte addresses
module md_bus_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import md_bus_pkg::*;

	localparam int TIMEOUT = 200;

	typedef struct packed {
		logic        z80;
		logic        rnw;
		logic [1:0]  lanes;
		logic [23:0] addr;
		logic [15:0] wdata;
		logic [15:0] exp_data;
	} step_t;

	logic        MCLK;
	logic        reset;
	m68k_req_t   m68k_req;
	z80_req_t    z80_req;
	bus_rsp_t    m68k_rsp;
	z80_rsp_t    z80_rsp;
	logic [23:0] rom_addr;
	logic        rom_req;
	logic        rom_ack = 1'b0;
	logic [15:0] rom_data = 16'h0000;
	logic        z80_busreq;
	logic        z80_reset;
	integer      seed = 13;
	int          rom_wait;
	logic        rom_busy = 1'b0;
	logic        exp_busreq;
	logic        exp_reset;

	// Columns are z80, rnw, lanes {uds,lds}, addr, wdata and expected read data
	step_t steps [$] = '{
		// Work RAM word and lane writes and a mirror read
		'{1'b0, 1'b0, 2'b11, 24'hE00000, 16'h1234, 16'h0000},
		'{1'b0, 1'b1, 2'b11, 24'hE00000, 16'h0000, 16'h1234},
		'{1'b0, 1'b0, 2'b11, 24'hE00002, 16'h5566, 16'h0000},
		'{1'b0, 1'b0, 2'b10, 24'hE00002, 16'hAB00, 16'h0000},
		'{1'b0, 1'b1, 2'b11, 24'hE00002, 16'h0000, 16'hAB66},
		'{1'b0, 1'b0, 2'b11, 24'hE00004, 16'h7788, 16'h0000},
		'{1'b0, 1'b0, 2'b01, 24'hE00004, 16'h00EF, 16'h0000},
		'{1'b0, 1'b1, 2'b11, 24'hE00004, 16'h0000, 16'h77EF},
		'{1'b0, 1'b1, 2'b11, 24'hE10000, 16'h0000, 16'h1234},
		// ROM reads, then reads past the ROM end and at unmapped addresses
		'{1'b0, 1'b1, 2'b11, 24'h000100, 16'h0000, 16'hFF7F},
		'{1'b0, 1'b1, 2'b11, 24'h007FFE, 16'h0000, 16'hC000},
		'{1'b0, 1'b1, 2'b11, 24'h008000, 16'h0000, 16'hFFFF},
		'{1'b0, 1'b1, 2'b11, 24'h400000, 16'h0000, 16'hFFFF},
		'{1'b0, 1'b1, 2'b11, 24'hA13000, 16'h0000, 16'hFFFF},
		// Control registers
		'{1'b0, 1'b1, 2'b11, 24'hA11100, 16'h0000, 16'hFFFF},
		'{1'b0, 1'b0, 2'b11, 24'hA11200, 16'h0100, 16'h0000},
		'{1'b0, 1'b0, 2'b11, 24'hA11100, 16'h0100, 16'h0000},
		'{1'b0, 1'b1, 2'b11, 24'hA11100, 16'h0000, 16'hFEFF},
		// 68000 in the Z80 area with the bus free
		'{1'b0, 1'b0, 2'b10, 24'hA00010, 16'h5A00, 16'h0000},
		'{1'b0, 1'b1, 2'b10, 24'hA00010, 16'h0000, 16'h5A5A},
		'{1'b1, 1'b1, 2'b00, 24'h000010, 16'h0000, 16'h005A},
		'{1'b0, 1'b0, 2'b01, 24'hA00021, 16'h00C3, 16'h0000},
		'{1'b1, 1'b1, 2'b00, 24'h002021, 16'h0000, 16'h00C3},
		// Bus taken back by the Z80
		'{1'b0, 1'b0, 2'b11, 24'hA11100, 16'h0000, 16'h0000},
		'{1'b0, 1'b1, 2'b10, 24'hA00010, 16'h0000, 16'hFFFF},
		'{1'b0, 1'b0, 2'b10, 24'hA00010, 16'h9900, 16'h0000},
		'{1'b1, 1'b1, 2'b00, 24'h000010, 16'h0000, 16'h005A},
		// Bank 1C0 shifted in LSB first puts the window at E00000
		'{1'b1, 1'b0, 2'b00, 24'h006000, 16'h0000, 16'h0000},
		'{1'b1, 1'b0, 2'b00, 24'h006000, 16'h0000, 16'h0000},
		'{1'b1, 1'b0, 2'b00, 24'h006000, 16'h0000, 16'h0000},
		'{1'b1, 1'b0, 2'b00, 24'h006000, 16'h0000, 16'h0000},
		'{1'b1, 1'b0, 2'b00, 24'h006000, 16'h0000, 16'h0000},
		'{1'b1, 1'b0, 2'b00, 24'h006000, 16'h0000, 16'h0000},
		'{1'b1, 1'b0, 2'b00, 24'h006000, 16'h0001, 16'h0000},
		'{1'b1, 1'b0, 2'b00, 24'h006000, 16'h0001, 16'h0000},
		'{1'b1, 1'b0, 2'b00, 24'h006000, 16'h0001, 16'h0000},
		'{1'b1, 1'b1, 2'b00, 24'h006000, 16'h0000, 16'h00FF},
		'{1'b1, 1'b1, 2'b00, 24'h008000, 16'h0000, 16'h0012},
		'{1'b1, 1'b1, 2'b00, 24'h008003, 16'h0000, 16'h0066},
		'{1'b1, 1'b0, 2'b00, 24'h008005, 16'h009C, 16'h0000},
		'{1'b0, 1'b1, 2'b11, 24'hE00004, 16'h0000, 16'h779C}
	};

	tb_clock tb_clock_i (.MCLK, .reset);

	md_bus_top #(.ROM_WORDS(32'h4000), .RAM_ADDR_W(15)) md_bus_top_i (
		.MCLK, .reset, .m68k_req, .z80_req, .rom_data, .rom_ack,
		.m68k_rsp, .z80_rsp, .rom_addr, .rom_req, .z80_busreq, .z80_reset
	);

	// --------------------
	// ROM model with toggle handshake
	always @(negedge MCLK) begin
		if (reset) begin
			rom_busy = 1'b0;
		end else if (rom_req != rom_ack) begin
			if (!rom_busy) begin
				rom_wait = $unsigned($random(seed)) % 5;
				rom_busy = 1'b1;
			end else if (rom_wait > 0) begin
				rom_wait = rom_wait - 1;
			end else begin
				rom_data <= ~rom_addr[15:0];
				rom_ack  <= rom_req;
				rom_busy = 1'b0;
			end
		end
	end

	always @(negedge MCLK) begin
		if (md_bus_top_i.md_bus_properties_i.error_count != 0) begin
			$display("A bound assertion on the DUT failed");
			$display("Test failed");
			$fatal(1, "assertion errors");
		end
	end

	// --------------------
	task automatic report_timeout(string what);
		$display("Timeout while waiting for %s", what);
		$display("Test failed");
		$fatal(1, "timeout");
	endtask

	task automatic check_value(string name, logic [15:0] exp, logic [15:0] act);
		assert (act === exp) else begin
			$display("FAIL at time %0t: %s expected %h, got %h", $time, name, exp, act);
			$display("Test failed");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	// Called and returns on a falling edge
	task automatic m68k_access(input step_t s, output logic [15:0] rdata);
		int n;
		m68k_req = '{as: 1'b1, rnw: s.rnw, uds: s.lanes[1], lds: s.lanes[0],
		             addr: s.addr[23:1], wdata: s.wdata};
		n = 0;
		do begin
			@(negedge MCLK);
			n++;
			if (n > TIMEOUT) report_timeout("68000 ack to rise");
		end while (m68k_rsp.ack !== 1'b1);
		rdata = m68k_rsp.rdata;
		m68k_req.as = 1'b0;
		n = 0;
		do begin
			@(negedge MCLK);
			n++;
			if (n > TIMEOUT) report_timeout("68000 ack to fall");
		end while (m68k_rsp.ack !== 1'b0);
	endtask

	task automatic z80_access(input step_t s, output logic [15:0] rdata);
		int n;
		z80_req = '{io: 1'b1, wr: !s.rnw, addr: s.addr[15:0], wdata: s.wdata[7:0]};
		n = 0;
		do begin
			@(negedge MCLK);
			n++;
			if (n > TIMEOUT) report_timeout("Z80 ack to rise");
		end while (z80_rsp.ack !== 1'b1);
		rdata = {8'h00, z80_rsp.rdata};
		z80_req.io = 1'b0;
		n = 0;
		do begin
			@(negedge MCLK);
			n++;
			if (n > TIMEOUT) report_timeout("Z80 ack to fall");
		end while (z80_rsp.ack !== 1'b0);
	endtask

	// --------------------
	initial begin
		int n;
		logic [15:0] rdata;
		m68k_req   = '0;
		z80_req    = '0;
		exp_busreq = 1'b0;
		exp_reset  = 1'b1;
		n = 0;
		do begin
			@(negedge MCLK);
			n++;
			if (n > TIMEOUT) report_timeout("reset release");
		end while (reset !== 1'b0);

		check_value("m68k_rsp.ack", 16'h0, m68k_rsp.ack);
		check_value("z80_rsp.ack", 16'h0, z80_rsp.ack);
		check_value("z80_busreq", 16'h0, z80_busreq);
		check_value("z80_reset", 16'h1, z80_reset);
		check_value("rom_req", rom_ack, rom_req);

		foreach (steps[i]) begin
			if (steps[i].z80) z80_access(steps[i], rdata);
			else m68k_access(steps[i], rdata);
			if (steps[i].rnw) begin
				check_value(steps[i].z80 ? "z80_rsp.rdata" : "m68k_rsp.rdata",
				            steps[i].exp_data, rdata);
			end
			// Control register writes take bit 8 on the upper lane
			if (!steps[i].z80 && !steps[i].rnw && steps[i].lanes[1] &&
			    steps[i].addr[23:12] == 12'hA11) begin
				if (steps[i].addr[11:8] == 4'h1) exp_busreq = steps[i].wdata[8];
				if (steps[i].addr[11:8] == 4'h2) exp_reset = !steps[i].wdata[8];
			end
			check_value("z80_busreq", exp_busreq, z80_busreq);
			check_value("z80_reset", exp_reset, z80_reset);
		end

		if (md_bus_top_i.md_bus_properties_i.error_count != 0) begin
			$display("Bound handshake assertions reported errors");
			$display("Test failed");
			$fatal(1, "assertion errors");
		end else begin
			$display("Test completed successfully");
			$finish;
		end
	end

endmodule

/* testbench/md_bus_properties.sv */
// Concurrent checks on the system bus top, attached with bind
// Covers the Z80 reset level after reset and the 68000 ack handshake
module md_bus_properties (
	input logic                  MCLK,
	input logic                  reset,
	input md_bus_pkg::m68k_req_t m68k_req,
	input md_bus_pkg::bus_rsp_t  m68k_rsp,
	input logic                  z80_reset
);
	timeunit 1ns;
	timeprecision 100ps;

	int unsigned error_count = 0;

	// Z80 stays in reset right after a bus reset
	z80_reset_after_reset: assert property (@(posedge MCLK) reset |=> z80_reset)
		else begin
			$error("z80_reset is low in the cycle after reset");
			error_count++;
		end

	// Ack is raised at an edge where the strobe was high
	ack_rises_with_as: assert property (@(posedge MCLK) disable iff (reset)
		$rose(m68k_rsp.ack) |-> $past(m68k_req.as))
		else begin
			$error("m68k_rsp.ack rose without m68k_req.as");
			error_count++;
		end

	// Ack gone one cycle after the strobe drops
	ack_falls_after_as: assert property (@(posedge MCLK) disable iff (reset)
		$fell(m68k_req.as) |=> !m68k_rsp.ack)
		else begin
			$error("m68k_rsp.ack still high one cycle after m68k_req.as fell");
			error_count++;
		end

endmodule

bind md_bus_top md_bus_properties md_bus_properties_i (
	.MCLK      (MCLK),
	.reset     (reset),
	.m68k_req  (m68k_req),
	.m68k_rsp  (m68k_rsp),
	.z80_reset (z80_reset)
);

/* testbench/tb_clock.sv */
// Clock and reset source for the bus testbench
// 10 ns clock, reset high over the first two rising edges
module tb_clock (
	output logic MCLK,
	output logic reset
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		MCLK = 1'b0;
		forever #5 MCLK = ~MCLK;
	end

	// Released on a falling edge, like every other DUT input
	initial begin
		reset = 1'b1;
		repeat (2) @(posedge MCLK);
		@(negedge MCLK);
		reset <= 1'b0;
	end

endmodule

/* hw/md_bus_top.sv */
// System bus top: main-bus controller, decoder, work RAM and Z80 local bus
// ROM_WORDS is the ROM size in words, RAM_ADDR_W the work RAM word-address width
// Z80 response comes from whichever side acknowledges
module md_bus_top #(
	parameter int unsigned ROM_WORDS  = 32'h0020_0000,
	parameter int          RAM_ADDR_W = 15
) (
	input  logic                  MCLK,
	input  logic                  reset,
	input  md_bus_pkg::m68k_req_t m68k_req,
	input  md_bus_pkg::z80_req_t  z80_req,
	input  logic [15:0]           rom_data,
	input  logic                  rom_ack,
	output md_bus_pkg::bus_rsp_t  m68k_rsp,
	output md_bus_pkg::z80_rsp_t  z80_rsp,
	output logic [23:0]           rom_addr,
	output logic                  rom_req,
	output logic                  z80_busreq,
	output logic                  z80_reset
);
	import md_bus_pkg::*;

	mbus_cmd_t    cmd;
	mbus_target_e target;
	z80_rsp_t     z80_win_rsp;
	z80_rsp_t     z80_local_rsp;
	logic [15:0]  ram_rdata;
	logic         ram_we_u;
	logic         ram_we_l;
	logic         zbus_sel;
	logic         zbus_ack;
	logic [7:0]   zbus_rdata;
	logic [8:0]   bank;

	// Window and local accesses never overlap for one Z80 cycle
	assign z80_rsp = z80_win_rsp.ack ? z80_win_rsp : z80_local_rsp;

	mbus_ctrl mbus_ctrl_i (
		.MCLK, .reset, .m68k_req, .z80_req, .target, .rom_data, .rom_ack,
		.ram_rdata, .zbus_ack, .zbus_rdata, .bank, .m68k_rsp, .z80_win_rsp,
		.cmd, .ram_we_u, .ram_we_l, .zbus_sel, .rom_addr, .rom_req,
		.z80_busreq, .z80_reset
	);

	mbus_decode #(.ROM_WORDS(ROM_WORDS)) mbus_decode_i (
		.cmd,
		.target
	);

	work_ram #(.RAM_ADDR_W(RAM_ADDR_W)) work_ram_i (
		.MCLK,
		.cmd,
		.we_u  (ram_we_u),
		.we_l  (ram_we_l),
		.rdata (ram_rdata)
	);

	zbus_unit zbus_unit_i (
		.MCLK, .reset, .cmd, .zbus_sel, .z80_req, .z80_busreq, .z80_reset,
		.zbus_ack, .zbus_rdata, .z80_local_rsp, .bank
	);

endmodule

/* hw/mbus_ctrl.sv */
// Main-bus controller: arbitration, access sequencing, Z80 control registers
// The 68000 always wins arbitration; the Z80 only reaches the main bus through
// its 8000-FFFF window. rom_addr is a word address, rom_ack must track rom_req
// across reset. Unmapped reads return all ones
module mbus_ctrl (
	input  logic                     MCLK,
	input  logic                     reset,
	input  md_bus_pkg::m68k_req_t    m68k_req,
	input  md_bus_pkg::z80_req_t     z80_req,
	input  md_bus_pkg::mbus_target_e target,
	input  logic [15:0]              rom_data,
	input  logic                     rom_ack,
	input  logic [15:0]              ram_rdata,
	input  logic                     zbus_ack,
	input  logic [7:0]               zbus_rdata,
	input  logic [8:0]               bank,
	output md_bus_pkg::bus_rsp_t     m68k_rsp,
	output md_bus_pkg::z80_rsp_t     z80_win_rsp,
	output md_bus_pkg::mbus_cmd_t    cmd,
	output logic                     ram_we_u,
	output logic                     ram_we_l,
	output logic                     zbus_sel,
	output logic [23:0]              rom_addr,
	output logic                     rom_req,
	output logic                     z80_busreq,
	output logic                     z80_reset
);
	import md_bus_pkg::*;

	mbus_state_e state;
	mbus_src_e   src;
	logic [15:0] data;
	// Window read byte waits here one cycle before the Z80 sees ack
	logic        z80_pend;

	assign rom_addr = {1'b0, cmd.addr};

	// Work RAM writes land at the end of MB_RAM_READ
	assign ram_we_u = (state == MB_RAM_READ) && !cmd.rnw && cmd.uds;
	assign ram_we_l = (state == MB_RAM_READ) && !cmd.rnw && cmd.lds;

	always_ff @(posedge MCLK) begin
		if (reset) begin
			state           <= MB_IDLE;
			src             <= SRC_M68K;
			m68k_rsp.ack    <= 1'b0;
			z80_win_rsp.ack <= 1'b0;
			z80_pend        <= 1'b0;
			zbus_sel        <= 1'b0;
			rom_req         <= rom_ack;
			z80_busreq      <= 1'b0;
			z80_reset       <= 1'b1;
		end else begin
			if (!m68k_req.as) m68k_rsp.ack <= 1'b0;
			if (!z80_req.io) z80_win_rsp.ack <= 1'b0;
			if (z80_pend) begin
				z80_win_rsp.ack <= 1'b1;
				z80_pend        <= 1'b0;
			end

			case (state)
				MB_IDLE: begin
					if (m68k_req.as && !m68k_rsp.ack) begin
						src   <= SRC_M68K;
						cmd   <= '{addr: m68k_req.addr, wdata: m68k_req.wdata,
						           rnw: m68k_req.rnw, uds: m68k_req.uds, lds: m68k_req.lds};
						data  <= OPEN_BUS;
						state <= MB_SELECT;
					end else if (z80_req.io && z80_req.addr[Z80_WINDOW_BIT] &&
					             !z80_win_rsp.ack && !z80_pend) begin
						// Bank selects the 32 KB page, odd bytes on the low lane
						src   <= SRC_Z80;
						cmd   <= '{addr: {bank, z80_req.addr[14:1]},
						           wdata: {z80_req.wdata, z80_req.wdata},
						           rnw: !z80_req.wr, uds: !z80_req.addr[0],
						           lds: z80_req.addr[0]};
						data  <= OPEN_BUS;
						state <= MB_SELECT;
					end
				end

				MB_SELECT: begin
					state <= MB_FINISH;
					case (target)
						TGT_ROM: begin
							rom_req <= !rom_ack;
							state   <= MB_ROM_READ;
						end
						TGT_ZBUS: begin
							zbus_sel <= 1'b1;
							state    <= MB_ZBUS_READ;
						end
						TGT_RAM: state <= MB_RAM_READ;
						TGT_CTRL: begin
							data <= {OPEN_BUS[15:9], !z80_busreq, OPEN_BUS[7:0]};
							if (!cmd.rnw && cmd.uds) begin
								if (cmd.addr[11:8] == 4'h1) z80_busreq <= cmd.wdata[8];
								if (cmd.addr[11:8] == 4'h2) z80_reset <= !cmd.wdata[8];
							end
						end
						default: ;
					endcase
				end

				MB_RAM_READ: begin
					data  <= ram_rdata;
					state <= MB_FINISH;
				end

				MB_ROM_READ: begin
					if (rom_req == rom_ack) begin
						data  <= rom_data;
						state <= MB_FINISH;
					end
				end

				MB_ZBUS_READ: begin
					if (zbus_ack) begin
						zbus_sel <= 1'b0;
						data     <= {zbus_rdata, zbus_rdata};
						state    <= MB_FINISH;
					end
				end

				MB_FINISH: begin
					if (src == SRC_M68K) begin
						m68k_rsp.rdata <= data;
						m68k_rsp.ack   <= 1'b1;
					end else begin
						// lds marks an odd Z80 address
						z80_win_rsp.rdata <= cmd.lds ? data[7:0] : data[15:8];
						z80_pend          <= 1'b1;
					end
					state <= MB_IDLE;
				end

				default: state <= MB_IDLE;
			endcase
		end
	end

endmodule

/* hw/zbus_unit.sv */
// Z80 local bus: 8 KB Z80 RAM and the 9-bit main-bus bank register
// Main-bus accesses have priority over local Z80 accesses below 7F00
// Z80 addresses 7F00-7FFF are not served and stall the Z80
// Anything other than Z80 RAM reads back as FF
module zbus_unit (
	input  logic                  MCLK,
	input  logic                  reset,
	input  md_bus_pkg::mbus_cmd_t cmd,
	input  logic                  zbus_sel,
	input  md_bus_pkg::z80_req_t  z80_req,
	input  logic                  z80_busreq,
	input  logic                  z80_reset,
	output logic                  zbus_ack,
	output logic [7:0]            zbus_rdata,
	output md_bus_pkg::z80_rsp_t  z80_local_rsp,
	output logic [8:0]            bank
);
	import md_bus_pkg::*;

	zbus_state_e state;
	logic        from_main;
	logic [14:0] zaddr;
	logic [7:0]  zwdata;
	logic        zwe;
	logic        local_sel;
	logic        bus_free;
	logic        zram_sel;
	logic [7:0]  zram_q;
	logic [7:0]  zrd;
	logic [7:0]  zram [8192];

	// 68000 owns the Z80 bus only with the Z80 halted and out of reset
	assign bus_free  = z80_busreq && !z80_reset;
	assign local_sel = z80_req.io && !z80_req.addr[Z80_WINDOW_BIT] && !(&z80_req.addr[14:8]);

	// 0000-1FFF, mirrored at 2000-3FFF
	assign zram_sel = !zaddr[14];
	assign zrd      = zram_sel ? zram_q : 8'hFF;

	always_ff @(posedge MCLK) begin
		if (zwe && zram_sel) zram[zaddr[12:0]] <= zwdata;
		zram_q <= zram[zaddr[12:0]];
	end

	// --------------------
	// Bank register, one bit per write, shifted in from the top
	always_ff @(posedge MCLK) begin
		if (reset) begin
			bank <= 9'd0;
		end else if (zwe && (zaddr[14:8] == Z80_BANK_PAGE)) begin
			bank <= {zwdata[0], bank[8:1]};
		end
	end

	// --------------------
	always_ff @(posedge MCLK) begin
		if (reset) begin
			state             <= ZB_IDLE;
			from_main         <= 1'b0;
			zwe               <= 1'b0;
			zbus_ack          <= 1'b0;
			z80_local_rsp.ack <= 1'b0;
		end else begin
			zwe <= 1'b0;
			if (!zbus_sel) zbus_ack <= 1'b0;
			if (!local_sel) z80_local_rsp.ack <= 1'b0;

			case (state)
				ZB_IDLE: begin
					if (zbus_sel && !zbus_ack) begin
						// Upper lane is the even byte
						zaddr     <= {cmd.addr[14:1], !cmd.uds};
						zwdata    <= cmd.uds ? cmd.wdata[15:8] : cmd.wdata[7:0];
						zwe       <= !cmd.rnw && bus_free;
						from_main <= 1'b1;
						state     <= ZB_READ;
					end else if (local_sel && !z80_local_rsp.ack) begin
						zaddr     <= z80_req.addr[14:0];
						zwdata    <= z80_req.wdata;
						zwe       <= z80_req.wr;
						from_main <= 1'b0;
						state     <= ZB_READ;
					end
				end

				ZB_READ: state <= ZB_FINISH;

				ZB_FINISH: begin
					if (from_main) begin
						zbus_rdata <= bus_free ? zrd : 8'hFF;
						zbus_ack   <= 1'b1;
					end else begin
						z80_local_rsp.rdata <= zrd;
						z80_local_rsp.ack   <= 1'b1;
					end
					state <= ZB_IDLE;
				end

				default: state <= ZB_IDLE;
			endcase
		end
	end

endmodule

/* hw/work_ram.sv */
// 68000 work RAM, two byte lanes with registered read data
// Only the low RAM_ADDR_W word-address bits are used, so the RAM mirrors
// over the whole E00000-FFFFFF region. Contents are undefined after power up
module work_ram #(
	parameter int RAM_ADDR_W = 15
) (
	input  logic                  MCLK,
	input  md_bus_pkg::mbus_cmd_t cmd,
	input  logic                  we_u,
	input  logic                  we_l,
	output logic [15:0]           rdata
);
	import md_bus_pkg::*;

	logic [7:0] mem_u [2**RAM_ADDR_W];
	logic [7:0] mem_l [2**RAM_ADDR_W];
	logic [RAM_ADDR_W-1:0] idx;

	assign idx = cmd.addr[RAM_ADDR_W:1];

	// Upper lane, even bytes
	always_ff @(posedge MCLK) begin
		if (we_u) mem_u[idx] <= cmd.wdata[15:8];
		rdata[15:8] <= mem_u[idx];
	end

	// Lower lane, odd bytes
	always_ff @(posedge MCLK) begin
		if (we_l) mem_l[idx] <= cmd.wdata[7:0];
		rdata[7:0] <= mem_l[idx];
	end

endmodule

/* hw/mbus_decode.sv */
// Main-bus address decoder, purely combinational
// ROM_WORDS is the ROM size in 16-bit words and wins over every other region
// Control registers decode only on address bits 23:8
module mbus_decode #(
	parameter int unsigned ROM_WORDS = 32'h0020_0000
) (
	input  md_bus_pkg::mbus_cmd_t    cmd,
	output md_bus_pkg::mbus_target_e target
);
	import md_bus_pkg::*;

	logic in_rom;
	logic in_zbus;
	logic in_ctrl;
	logic in_ram;

	// --------------------
	// Region compares
	assign in_rom  = 32'(cmd.addr) < ROM_WORDS;

	// A00000-A0FFFF, both halves of the Z80 area
	assign in_zbus = cmd.addr[23:16] == ZBUS_BASE;

	// A111xx bus request, A112xx Z80 reset
	assign in_ctrl = (cmd.addr[23:12] == CTRL_BASE) &&
	                 ((cmd.addr[11:8] == 4'h1) || (cmd.addr[11:8] == 4'h2));

	// E00000-FFFFFF, work RAM mirrors
	assign in_ram  = cmd.addr[23:21] == RAM_TOP_BITS;

	// --------------------
	always_comb begin
		if (in_rom) begin
			target = TGT_ROM;
		end else if (in_zbus) begin
			target = TGT_ZBUS;
		end else if (in_ctrl) begin
			target = TGT_CTRL;
		end else if (in_ram) begin
			target = TGT_RAM;
		end else begin
			target = TGT_NONE;
		end
	end

endmodule

/* hw/md_bus_pkg.sv */
// Shared types and address map of the console system bus
// Main-bus addresses are 68000 word addresses (byte address bits 23:1)
// Lane enables uds/lds are active high, strobes are plain levels
package md_bus_pkg;

	// --------------------
	// Master ports
	typedef struct packed {
		logic        as;
		logic        rnw;
		logic        uds;
		logic        lds;
		logic [23:1] addr;
		logic [15:0] wdata;
	} m68k_req_t;

	typedef struct packed {
		logic        ack;
		logic [15:0] rdata;
	} bus_rsp_t;

	typedef struct packed {
		logic        io;
		logic        wr;
		logic [15:0] addr;
		logic [7:0]  wdata;
	} z80_req_t;

	typedef struct packed {
		logic       ack;
		logic [7:0] rdata;
	} z80_rsp_t;

	// Latched main-bus command
	typedef struct packed {
		logic [23:1] addr;
		logic [15:0] wdata;
		logic        rnw;
		logic        uds;
		logic        lds;
	} mbus_cmd_t;

	// --------------------
	typedef enum logic [2:0] {TGT_NONE, TGT_ROM, TGT_ZBUS, TGT_CTRL, TGT_RAM} mbus_target_e;

	typedef enum logic [2:0] {
		MB_IDLE, MB_SELECT, MB_RAM_READ, MB_ROM_READ, MB_ZBUS_READ, MB_FINISH
	} mbus_state_e;

	typedef enum logic {SRC_M68K, SRC_Z80} mbus_src_e;

	typedef enum logic [1:0] {ZB_IDLE, ZB_READ, ZB_FINISH} zbus_state_e;

	// --------------------
	// Address map
	localparam logic [7:0]  ZBUS_BASE      = 8'hA0;
	localparam logic [11:0] CTRL_BASE      = 12'hA11;
	localparam logic [2:0]  RAM_TOP_BITS   = 3'b111;
	localparam int          Z80_WINDOW_BIT = 15;
	// Page of the 15-bit Z80 local address
	localparam logic [6:0]  Z80_BANK_PAGE  = 7'h60;
	localparam logic [15:0] OPEN_BUS       = 16'hFFFF;

endpackage
